// ==== src.f ====
+incdir+include
hw/vjob_pkg.sv
hw/vjob_apb_regs.sv
hw/vjob_cmd_gen.sv
hw/vjob_line_unpack.sv
hw/vjob_fifo.sv
hw/vertex_job_control.sv
verif/vjob_assert.sv
verif/vjob_checker.sv
verif/tb_vertex_job_control.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_vertex_job_control
FILELIST  = src.f

SRCS = $(shell grep -v '^+' $(FILELIST)) include/vjob_params.svh
BIN  = obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf obj_dir

// ==== verif/tb_vertex_job_control.sv ====
////////////////////
// vertex job controller testbench
// APB driver, memory model and job sequencing
////////////////////

`default_nettype none

`include "vjob_params.svh"

module tb_vertex_job_control import vjob_pkg::*;;

	logic        clock = 1'b0;
	logic        rstn;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [7:0]  paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        pready;
	logic        pslverr;
	logic        cmd_valid;
	logic        cmd_ready = 1'b0;
	logic [31:0] cmd_addr;
	array_tag_e  cmd_tag;
	logic [3:0]  cmd_count;
	logic        rsp_valid = 1'b0;
	array_tag_e  rsp_tag = TAG_DEGREE;
	logic [3:0]  rsp_count = '0;
	logic [255:0] rsp_data = '0;
	logic        vertex_request = 1'b0;
	logic        vertex_valid;
	logic [31:0] vertex_id;
	logic [31:0] degree;
	logic [31:0] edges_idx;
	int          error_count;
	int          check_count;
	int          pending;

	logic [31:0] rng = 32'h8bd8;
	logic        req_enable = 1'b0;
	int          req_gap = 1;
	int          cycle = 0;
	logic [31:0] pend_addr[$];
	array_tag_e  pend_tag[$];
	logic [3:0]  pend_cnt[$];
	int          pend_due[$];

	vertex_job_control dut (.*);

	vjob_checker chk (
		.clock(clock), .rstn(rstn), .psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pslverr(pslverr),
		.cmd_valid(cmd_valid), .cmd_ready(cmd_ready), .cmd_addr(cmd_addr),
		.cmd_tag(cmd_tag), .cmd_count(cmd_count), .push(dut.push),
		.vertex_request(vertex_request), .vertex_valid(vertex_valid),
		.vertex_id(vertex_id), .degree(degree), .edges_idx(edges_idx),
		.error_count(error_count), .check_count(check_count), .pending(pending)
	);

	initial begin
		forever #20 clock = ~clock;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		return s ^ (s << 5);
	endfunction

	function logic [31:0] next_rand();
		rng = xorshift(rng);
		return rng;
	endfunction

	function automatic logic [31:0] mem_word(input logic [31:0] addr);
		logic [31:0] x;
		x = addr ^ 32'h5bd1e995;
		x = x ^ (x << 13);
		x = x ^ (x >> 7);
		return x ^ (x << 17);
	endfunction

	// count words from addr, unused words zero
	function automatic logic [255:0] build_line(input logic [31:0] addr, input logic [3:0] cnt);
		vjob_line_u line;
		line.raw = '0;
		for (int i = 0; i < int'(cnt); i++)
			line.word[i] = mem_word(addr + 32'(4 * i));
		return line.raw;
	endfunction

	////////////////////
	// memory model and request source
	////////////////////
	always @(posedge clock) begin : memory_model
		int hit;
		cycle++;
		if (cmd_valid && cmd_ready) begin
			pend_addr.push_back(cmd_addr);
			pend_tag.push_back(cmd_tag);
			pend_cnt.push_back(cmd_count);
			pend_due.push_back(cycle + 1 + int'(next_rand() % 32'd6));
		end
		hit = -1;
		for (int i = 0; i < pend_due.size(); i++)
			if (hit < 0 && pend_due[i] <= cycle)
				hit = i;
		rsp_valid <= 1'b0;
		if (hit >= 0) begin
			rsp_valid <= 1'b1;
			rsp_tag   <= pend_tag[hit];
			rsp_count <= pend_cnt[hit];
			rsp_data  <= build_line(pend_addr[hit], pend_cnt[hit]);
			pend_addr.delete(hit);
			pend_tag.delete(hit);
			pend_cnt.delete(hit);
			pend_due.delete(hit);
		end
		cmd_ready <= (next_rand() % 32'd4) != 32'd0;
		vertex_request <= req_enable && ((next_rand() % 32'(req_gap)) == 32'd0);
	end

	////////////////////
	// APB driver and waits
	////////////////////
	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
		@(posedge clock);
		psel <= 1'b1;
		pwrite <= 1'b1;
		paddr <= addr;
		pwdata <= data;
		@(posedge clock);
		penable <= 1'b1;
		@(posedge clock);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
		@(posedge clock);
		psel <= 1'b1;
		pwrite <= 1'b0;
		paddr <= addr;
		@(posedge clock);
		penable <= 1'b1;
		@(negedge clock);
		data = prdata;
		@(posedge clock);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic report_timeout(input string what);
		$display("timeout while waiting for %s", what);
		$display("TB FAILED");
		$finish;
	endtask

	task automatic wait_job_done();
		logic [31:0] status;
		int tries;
		tries = 0;
		status = '0;
		while (!status[1] && tries < 500) begin
			apb_read(8'h14, status);
			tries++;
		end
		if (!status[1])
			report_timeout("job done");
	endtask

	task automatic wait_drained();
		int cycles;
		cycles = 0;
		@(negedge clock);
		while (pending != 0 && cycles < 4000) begin
			@(negedge clock);
			cycles++;
		end
		if (pending != 0)
			report_timeout("all vertices");
	endtask

	task automatic run_job(input logic [23:0] num, input logic [31:0] db,
		input logic [31:0] eb, input logic [31:0] fid);
		apb_write(8'h04, {8'h00, num});
		apb_write(8'h08, db);
		apb_write(8'h0C, eb);
		apb_write(8'h10, fid);
		apb_write(8'h00, 32'd1);
		wait_job_done();
	endtask

	initial begin : sequencer
		logic [31:0] data;
		rstn = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		repeat (3) @(posedge clock);
		rstn <= 1'b1;
		// register readback and a bad offset
		apb_write(8'h04, 32'd20);
		apb_write(8'h08, 32'h1000);
		apb_write(8'h0C, 32'h4000);
		apb_write(8'h10, 32'd100);
		for (int a = 0; a <= 8'h18; a += 4)
			apb_read(8'(a), data);
		apb_write(8'h24, 32'hdead);
		apb_read(8'h04, data);
		// first job, busy then done
		req_gap <= 3;
		req_enable <= 1'b1;
		apb_write(8'h00, 32'd1);
		apb_read(8'h14, data);
		wait_job_done();
		wait_drained();
		// random jobs under stalls and sparse requests
		for (int j = 0; j < 6; j++) begin
			req_gap <= 1 + int'(next_rand() % 32'd4);
			run_job(24'(next_rand() % 32'd40) + 24'd1, next_rand() & 32'h000f_ffe0,
				next_rand() & 32'h000f_fffc, next_rand());
			wait_drained();
		end
		// empty job, then requests to an empty queue
		req_enable <= 1'b0;
		run_job(24'd0, 32'h2000, 32'h3000, 32'd7);
		req_gap <= 1;
		req_enable <= 1'b1;
		repeat (6) @(posedge clock);
		req_enable <= 1'b0;
		// fill the queue, then drain it
		run_job(24'd5, 32'h8000, 32'h9000, 32'd50);
		req_gap <= 2;
		req_enable <= 1'b1;
		wait_drained();
		repeat (4) @(posedge clock);
		$display("checks %0d errors %0d", check_count, error_count);
		if (error_count == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verif/vjob_checker.sv ====
////////////////////
// vertex job checker
// predicts commands, vertices and register reads
////////////////////

`default_nettype none

`include "vjob_params.svh"

module vjob_checker (
	input  wire logic        clock,
	input  wire logic        rstn,
	input  wire logic        psel,
	input  wire logic        penable,
	input  wire logic        pwrite,
	input  wire logic [7:0]  paddr,
	input  wire logic [31:0] pwdata,
	input  wire logic [31:0] prdata,
	input  wire logic        pslverr,
	input  wire logic        cmd_valid,
	input  wire logic        cmd_ready,
	input  wire logic [31:0] cmd_addr,
	input  wire logic        cmd_tag,
	input  wire logic [3:0]  cmd_count,
	input  wire logic        push,
	input  wire logic        vertex_request,
	input  wire logic        vertex_valid,
	input  wire logic [31:0] vertex_id,
	input  wire logic [31:0] degree,
	input  wire logic [31:0] edges_idx,
	output int               error_count,
	output int               check_count,
	output int               pending
);

	logic [23:0] r_num;
	logic [31:0] r_deg;
	logic [31:0] r_edg;
	logic [31:0] r_first;
	logic [36:0] cmd_q[$];
	logic [95:0] vtx_q[$];
	int          occ;
	logic        exp_valid;
	logic        pop_now;
	logic        exp_busy;
	logic        exp_done;
	logic [23:0] push_left;

	// memory contents, a fixed hash of the byte address
	function automatic logic [31:0] word_at(input logic [31:0] addr);
		logic [31:0] x;
		x = addr ^ 32'h5bd1e995;
		x = x ^ (x << 13);
		x = x ^ (x >> 7);
		return x ^ (x << 17);
	endfunction

	task automatic report_mismatch(input string msg);
		error_count++;
		$display("FAIL t=%0t %s", $time, msg);
	endtask

	// expected commands, vertices and status of a new job
	task automatic load_job();
		logic [23:0] rem;
		logic [31:0] off;
		logic [3:0]  cnt;
		exp_busy = (r_num != '0);
		exp_done = (r_num == '0);
		push_left = r_num;
		rem = r_num;
		off = '0;
		while (rem != '0) begin
			cnt = (rem > 24'd8) ? 4'd8 : rem[3:0];
			cmd_q.push_back({r_deg + off, 1'b0, cnt});
			cmd_q.push_back({r_edg + off, 1'b1, cnt});
			off = off + 32'd32;
			rem = rem - 24'(cnt);
		end
		for (int i = 0; i < int'(r_num); i++)
			vtx_q.push_back({r_first + 32'(i), word_at(r_deg + 32'(4 * i)),
				word_at(r_edg + 32'(4 * i))});
	endtask

	task automatic check_read();
		logic [31:0] exp;
		logic        known;
		known = 1'b1;
		exp = '0;
		case (paddr)
			8'h00: exp = '0;
			8'h04: exp = {8'h00, r_num};
			8'h08: exp = r_deg;
			8'h0C: exp = r_edg;
			8'h10: exp = r_first;
			8'h14: exp = {30'd0, exp_done, exp_busy};
			default: known = 1'b0;
		endcase
		check_count++;
		if (pslverr !== !known)
			report_mismatch($sformatf("pslverr %b at offset %h", pslverr, paddr));
		else if (known && prdata !== exp)
			report_mismatch($sformatf("read %h got %h exp %h", paddr, prdata, exp));
	endtask

	always @(posedge clock) begin
		if (!rstn) begin
			error_count = 0;
			check_count = 0;
			occ = 0;
			exp_valid = 1'b0;
			exp_busy = 1'b0;
			exp_done = 1'b0;
			push_left = '0;
			cmd_q.delete();
			vtx_q.delete();
		end else begin
			//////////////////// APB
			if (psel && penable && pwrite) begin
				case (paddr)
					8'h04: r_num = pwdata[23:0];
					8'h08: r_deg = pwdata;
					8'h0C: r_edg = pwdata;
					8'h10: r_first = pwdata;
					8'h00: if (pwdata[0] && !exp_busy) load_job();
					default: ;
				endcase
			end
			if (psel && penable && !pwrite)
				check_read();
			//////////////////// commands
			if (cmd_valid && cmd_ready) begin
				check_count++;
				if (cmd_q.size() == 0)
					report_mismatch($sformatf("unexpected command at %h", cmd_addr));
				else if (cmd_q[0] !== {cmd_addr, cmd_tag, cmd_count})
					report_mismatch($sformatf("command %h got %h", cmd_q[0],
						{cmd_addr, cmd_tag, cmd_count}));
				if (cmd_q.size() != 0)
					void'(cmd_q.pop_front());
			end
			//////////////////// vertices
			check_count++;
			if (vertex_valid !== exp_valid)
				report_mismatch($sformatf("vertex_valid %b exp %b", vertex_valid, exp_valid));
			if (vertex_valid) begin
				if (vtx_q.size() == 0)
					report_mismatch("unexpected vertex");
				else if (vtx_q[0] !== {vertex_id, degree, edges_idx})
					report_mismatch($sformatf("vertex got %h exp %h",
						{vertex_id, degree, edges_idx}, vtx_q[0]));
				if (vtx_q.size() != 0)
					void'(vtx_q.pop_front());
			end
			// the last push of a job ends it
			if (push && exp_busy) begin
				push_left = push_left - 24'd1;
				if (push_left == '0) begin
					exp_busy = 1'b0;
					exp_done = 1'b1;
				end
			end
			// queue occupancy gives the next valid
			pop_now = vertex_request && (occ != 0);
			exp_valid = pop_now;
			occ = occ + (push ? 1 : 0) - (pop_now ? 1 : 0);
		end
		pending = cmd_q.size() + vtx_q.size();
	end

endmodule

`default_nettype wire

// ==== verif/vjob_assert.sv ====
////////////////////
// vertex job protocol assertions
// bound to the controller top
////////////////////

`default_nettype none

`include "vjob_params.svh"

module vjob_assert (
	input wire logic                        clock,
	input wire logic                        rstn,
	input wire logic                        cmd_valid,
	input wire logic                        cmd_ready,
	input wire logic [`VJOB_ADDR_BITS-1:0]  cmd_addr,
	input wire logic                        cmd_tag,
	input wire logic [`VJOB_COUNT_BITS-1:0] cmd_count,
	input wire logic                        pready
);

	// payload frozen while the command stalls
	stall_stable: assert property (@(posedge clock) disable iff (!rstn)
		cmd_valid && !cmd_ready |=> cmd_valid && $stable(cmd_addr) &&
		$stable(cmd_tag) && $stable(cmd_count))
		else $error("command payload changed during a stall");

	ready_high: assert property (@(posedge clock) disable iff (!rstn) pready)
		else $error("pready dropped");

	no_cmd_in_reset: assert property (@(posedge clock) !rstn |-> !cmd_valid)
		else $error("cmd_valid high during reset");

endmodule

bind vertex_job_control vjob_assert u_assert (
	.clock(clock), .rstn(rstn), .cmd_valid(cmd_valid), .cmd_ready(cmd_ready),
	.cmd_addr(cmd_addr), .cmd_tag(cmd_tag), .cmd_count(cmd_count), .pready(pready)
);

`default_nettype wire

// ==== hw/vertex_job_control.sv ====
////////////////////
// vertex job controller top
// APB setup, chunked array reads and the vertex job queue
////////////////////

`default_nettype none

`include "vjob_params.svh"

module vertex_job_control import vjob_pkg::*; (
	input  wire logic                           clock,
	input  wire logic                           rstn,
	// APB
	input  wire logic                           psel,
	input  wire logic                           penable,
	input  wire logic                           pwrite,
	input  wire logic [`VJOB_APB_ADDR_BITS-1:0] paddr,
	input  wire logic [`VJOB_ADDR_BITS-1:0]     pwdata,
	output logic      [`VJOB_ADDR_BITS-1:0]     prdata,
	output logic                                pready,
	output logic                                pslverr,
	// read commands
	output logic                                cmd_valid,
	input  wire logic                           cmd_ready,
	output logic      [`VJOB_ADDR_BITS-1:0]     cmd_addr,
	output array_tag_e                          cmd_tag,
	output logic      [`VJOB_COUNT_BITS-1:0]    cmd_count,
	// read responses
	input  wire logic                           rsp_valid,
	input  wire array_tag_e                     rsp_tag,
	input  wire logic [`VJOB_COUNT_BITS-1:0]    rsp_count,
	input  wire logic [`VJOB_LINE_BITS-1:0]     rsp_data,
	// vertex jobs
	input  wire logic                           vertex_request,
	output logic                                vertex_valid,
	output logic      [`VJOB_VERTEX_BITS-1:0]   vertex_id,
	output logic      [`VJOB_VERTEX_BITS-1:0]   degree,
	output logic      [`VJOB_VERTEX_BITS-1:0]   edges_idx
);

	logic [`VJOB_NUM_BITS-1:0]    num_vertices;
	logic [`VJOB_ADDR_BITS-1:0]   degree_base;
	logic [`VJOB_ADDR_BITS-1:0]   edges_base;
	logic [`VJOB_VERTEX_BITS-1:0] first_id;
	logic                         start;
	logic                         busy;
	logic                         done;
	logic                         unpack_idle;
	logic                         fifo_room;
	logic                         pushed_last;
	logic                         push;
	logic [`VJOB_VERTEX_BITS-1:0] unpack_id;
	logic [`VJOB_VERTEX_BITS-1:0] unpack_degree;
	logic [`VJOB_VERTEX_BITS-1:0] unpack_edges;

	vjob_apb_regs u_regs (
		.clock(clock), .rstn(rstn),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
		.prdata(prdata), .pready(pready), .pslverr(pslverr),
		.busy(busy), .done(done),
		.num_vertices(num_vertices), .degree_base(degree_base), .edges_base(edges_base),
		.first_id(first_id), .start(start)
	);

	vjob_cmd_gen u_cmd_gen (
		.clock(clock), .rstn(rstn), .start(start),
		.num_vertices(num_vertices), .degree_base(degree_base), .edges_base(edges_base),
		.unpack_idle(unpack_idle), .fifo_room(fifo_room), .pushed_last(pushed_last),
		.cmd_ready(cmd_ready), .cmd_valid(cmd_valid), .cmd_addr(cmd_addr),
		.cmd_tag(cmd_tag), .cmd_count(cmd_count), .busy(busy), .done(done)
	);

	vjob_line_unpack u_unpack (
		.clock(clock), .rstn(rstn), .start(start), .first_id(first_id),
		.rsp_valid(rsp_valid), .rsp_tag(rsp_tag), .rsp_count(rsp_count), .rsp_data(rsp_data),
		.unpack_idle(unpack_idle), .pushed_last(pushed_last), .push(push),
		.vertex_id(unpack_id), .degree(unpack_degree), .edges_idx(unpack_edges)
	);

	vjob_fifo u_fifo (
		.clock(clock), .rstn(rstn), .push(push),
		.vertex_id(unpack_id), .degree(unpack_degree), .edges_idx(unpack_edges),
		.vertex_request(vertex_request), .fifo_room(fifo_room), .vertex_valid(vertex_valid),
		.vertex_id_out(vertex_id), .degree_out(degree), .edges_idx_out(edges_idx)
	);

endmodule

`default_nettype wire

// ==== hw/vjob_fifo.sv ====
////////////////////
// vertex job queue
// circular buffer with a registered pop stage
////////////////////

`default_nettype none

`include "vjob_params.svh"

module vjob_fifo (
	input  wire logic                         clock,
	input  wire logic                         rstn,
	input  wire logic                         push,
	input  wire logic [`VJOB_VERTEX_BITS-1:0] vertex_id,
	input  wire logic [`VJOB_VERTEX_BITS-1:0] degree,
	input  wire logic [`VJOB_VERTEX_BITS-1:0] edges_idx,
	input  wire logic                         vertex_request,
	output logic                              fifo_room,
	output logic                              vertex_valid,
	output logic      [`VJOB_VERTEX_BITS-1:0] vertex_id_out,
	output logic      [`VJOB_VERTEX_BITS-1:0] degree_out,
	output logic      [`VJOB_VERTEX_BITS-1:0] edges_idx_out
);

	localparam int PTR_BITS   = $clog2(`VJOB_FIFO_DEPTH);
	localparam int CNT_BITS   = PTR_BITS + 1;
	localparam int ENTRY_BITS = 3 * `VJOB_VERTEX_BITS;

	logic [ENTRY_BITS-1:0] mem [`VJOB_FIFO_DEPTH];
	logic [PTR_BITS-1:0]   wr_ptr;
	logic [PTR_BITS-1:0]   rd_ptr;
	logic [CNT_BITS-1:0]   count;
	logic                  do_push;
	logic                  do_pop;

	assign do_push = push && (count != CNT_BITS'(`VJOB_FIFO_DEPTH));
	assign do_pop  = vertex_request && (count != '0);

	// room for a full line of vertices
	assign fifo_room = (CNT_BITS'(`VJOB_FIFO_DEPTH) - count) >= CNT_BITS'(`VJOB_LINE_VERTICES);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr       <= '0;
			rd_ptr       <= '0;
			count        <= '0;
			vertex_valid <= 1'b0;
		end else begin
			vertex_valid <= do_pop;
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: ;
			endcase
		end
	end

	// storage and output data
	always_ff @(posedge clock) begin
		if (do_push)
			mem[wr_ptr] <= {vertex_id, degree, edges_idx};
		if (do_pop)
			{vertex_id_out, degree_out, edges_idx_out} <= mem[rd_ptr];
	end

endmodule

`default_nettype wire

// ==== hw/vjob_line_unpack.sv ====
////////////////////
// vertex line unpacker
// holds the degree and edges lines of a chunk
// and pushes one vertex per cycle
////////////////////

`default_nettype none

`include "vjob_params.svh"

module vjob_line_unpack import vjob_pkg::*; (
	input  wire logic                         clock,
	input  wire logic                         rstn,
	input  wire logic                         start,
	input  wire logic [`VJOB_VERTEX_BITS-1:0] first_id,
	input  wire logic                         rsp_valid,
	input  wire array_tag_e                   rsp_tag,
	input  wire logic [`VJOB_COUNT_BITS-1:0]  rsp_count,
	input  wire logic [`VJOB_LINE_BITS-1:0]   rsp_data,
	output logic                              unpack_idle,
	output logic                              pushed_last,
	output logic                              push,
	output logic      [`VJOB_VERTEX_BITS-1:0] vertex_id,
	output logic      [`VJOB_VERTEX_BITS-1:0] degree,
	output logic      [`VJOB_VERTEX_BITS-1:0] edges_idx
);

	localparam int IDX_BITS = $clog2(`VJOB_LINE_VERTICES);

	vjob_line_u                   degree_line;
	vjob_line_u                   edges_line;
	logic [`VJOB_COUNT_BITS-1:0]  line_count;
	logic                         have_degree;
	logic                         have_edges;
	logic [IDX_BITS-1:0]          word_idx;
	logic [`VJOB_VERTEX_BITS-1:0] id_next;
	logic                         last_word;

	// both lines in hand
	assign push = have_degree && have_edges;
	assign last_word = ({1'b0, word_idx} == (line_count - 1'b1));
	assign pushed_last = push && last_word;
	assign unpack_idle = !have_degree && !have_edges;

	assign vertex_id = id_next;
	assign degree    = degree_line.word[word_idx];
	assign edges_idx = edges_line.word[word_idx];

	////////////////////
	// line capture
	////////////////////
	always_ff @(posedge clock) begin
		if (rsp_valid) begin
			// both lines of a chunk carry the same count
			line_count <= rsp_count;
			if (rsp_tag == TAG_DEGREE)
				degree_line.raw <= rsp_data;
			else
				edges_line.raw <= rsp_data;
		end
	end

	////////////////////
	// unpack control
	////////////////////
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			have_degree <= 1'b0;
			have_edges  <= 1'b0;
			word_idx    <= '0;
			id_next     <= '0;
		end else begin
			// ids run across the whole job
			if (start)
				id_next <= first_id;
			if (push) begin
				id_next <= id_next + 1'b1;
				if (last_word) begin
					word_idx    <= '0;
					have_degree <= 1'b0;
					have_edges  <= 1'b0;
				end else begin
					word_idx <= word_idx + 1'b1;
				end
			end
			if (rsp_valid) begin
				case (rsp_tag)
					TAG_DEGREE: have_degree <= 1'b1;
					TAG_EDGES:  have_edges <= 1'b1;
					default:    ;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/vjob_cmd_gen.sv ====
////////////////////
// vertex job command generator
// walks both arrays one line per chunk
// and issues a degree then an edges read
////////////////////

`default_nettype none

`include "vjob_params.svh"

module vjob_cmd_gen import vjob_pkg::*; (
	input  wire logic                        clock,
	input  wire logic                        rstn,
	input  wire logic                        start,
	input  wire logic [`VJOB_NUM_BITS-1:0]   num_vertices,
	input  wire logic [`VJOB_ADDR_BITS-1:0]  degree_base,
	input  wire logic [`VJOB_ADDR_BITS-1:0]  edges_base,
	input  wire logic                        unpack_idle,
	input  wire logic                        fifo_room,
	input  wire logic                        pushed_last,
	input  wire logic                        cmd_ready,
	output logic                             cmd_valid,
	output logic      [`VJOB_ADDR_BITS-1:0]  cmd_addr,
	output array_tag_e                       cmd_tag,
	output logic      [`VJOB_COUNT_BITS-1:0] cmd_count,
	output logic                             busy,
	output logic                             done
);

	localparam logic [2:0] S_RESET      = 3'd0;
	localparam logic [2:0] S_IDLE       = 3'd1;
	localparam logic [2:0] S_CMD_DEG    = 3'd2;
	localparam logic [2:0] S_CMD_EDGES  = 3'd3;
	localparam logic [2:0] S_WAIT_CHUNK = 3'd4;

	logic [2:0]                  state;
	logic [`VJOB_NUM_BITS-1:0]   remaining;
	logic [`VJOB_ADDR_BITS-1:0]  chunk_offset;
	logic                        chunk_pending;
	logic [`VJOB_COUNT_BITS-1:0] chunk_count;
	logic                        issue_chunk;

	// full line, or whatever is left
	assign chunk_count = (remaining > `VJOB_LINE_VERTICES) ?
		`VJOB_COUNT_BITS'(`VJOB_LINE_VERTICES) : remaining[`VJOB_COUNT_BITS-1:0];

	// only one chunk in flight, and the queue must take a whole line
	assign issue_chunk = (state == S_WAIT_CHUNK) && !chunk_pending && unpack_idle && fifo_room;

	assign cmd_valid = (state == S_CMD_DEG) || (state == S_CMD_EDGES);
	assign busy = (state != S_IDLE) && (state != S_RESET);

	////////////////////
	// job FSM
	////////////////////
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state         <= S_RESET;
			remaining     <= '0;
			chunk_offset  <= '0;
			chunk_pending <= 1'b0;
			done          <= 1'b0;
		end else begin
			case (state)
				S_RESET: state <= S_IDLE;
				S_IDLE: begin
					if (start) begin
						// empty job finishes on the spot
						done <= (num_vertices == '0);
						if (num_vertices != '0) begin
							remaining     <= num_vertices;
							chunk_offset  <= '0;
							chunk_pending <= 1'b0;
							state         <= S_WAIT_CHUNK;
						end
					end
				end
				S_WAIT_CHUNK: begin
					if (chunk_pending) begin
						if (pushed_last) begin
							chunk_pending <= 1'b0;
							if (remaining == '0) begin
								done  <= 1'b1;
								state <= S_IDLE;
							end
						end
					end else if (issue_chunk) begin
						remaining <= remaining - chunk_count;
						state     <= S_CMD_DEG;
					end
				end
				S_CMD_DEG: begin
					if (cmd_ready)
						state <= S_CMD_EDGES;
				end
				S_CMD_EDGES: begin
					if (cmd_ready) begin
						chunk_offset  <= chunk_offset + `VJOB_ADDR_BITS'(`VJOB_LINE_BYTES);
						chunk_pending <= 1'b1;
						state         <= S_WAIT_CHUNK;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// command payload, held while stalled
	always_ff @(posedge clock) begin
		if (issue_chunk) begin
			cmd_addr  <= degree_base + chunk_offset;
			cmd_tag   <= TAG_DEGREE;
			cmd_count <= chunk_count;
		end else if ((state == S_CMD_DEG) && cmd_ready) begin
			cmd_addr <= edges_base + chunk_offset;
			cmd_tag  <= TAG_EDGES;
		end
	end

endmodule

`default_nettype wire

// ==== hw/vjob_apb_regs.sv ====
////////////////////
// vertex job APB registers
// job setup, start pulse and status readback
////////////////////

`default_nettype none

`include "vjob_params.svh"

module vjob_apb_regs (
	input  wire logic                           clock,
	input  wire logic                           rstn,
	input  wire logic                           psel,
	input  wire logic                           penable,
	input  wire logic                           pwrite,
	input  wire logic [`VJOB_APB_ADDR_BITS-1:0] paddr,
	input  wire logic [`VJOB_ADDR_BITS-1:0]     pwdata,
	output logic      [`VJOB_ADDR_BITS-1:0]     prdata,
	output logic                                pready,
	output logic                                pslverr,
	input  wire logic                           busy,
	input  wire logic                           done,
	output logic      [`VJOB_NUM_BITS-1:0]      num_vertices,
	output logic      [`VJOB_ADDR_BITS-1:0]     degree_base,
	output logic      [`VJOB_ADDR_BITS-1:0]     edges_base,
	output logic      [`VJOB_VERTEX_BITS-1:0]   first_id,
	output logic                                start
);

	localparam logic [`VJOB_APB_ADDR_BITS-1:0] REG_CONTROL = 'h00;
	localparam logic [`VJOB_APB_ADDR_BITS-1:0] REG_NUM     = 'h04;
	localparam logic [`VJOB_APB_ADDR_BITS-1:0] REG_DEGREE  = 'h08;
	localparam logic [`VJOB_APB_ADDR_BITS-1:0] REG_EDGES   = 'h0C;
	localparam logic [`VJOB_APB_ADDR_BITS-1:0] REG_FIRST   = 'h10;
	localparam logic [`VJOB_APB_ADDR_BITS-1:0] REG_STATUS  = 'h14;

	logic access;
	logic known_offset;

	// zero wait states
	assign pready = 1'b1;

	assign access = psel && penable;
	assign known_offset = (paddr == REG_CONTROL) || (paddr == REG_NUM) ||
		(paddr == REG_DEGREE) || (paddr == REG_EDGES) ||
		(paddr == REG_FIRST) || (paddr == REG_STATUS);

	assign pslverr = access && !known_offset;

	////////////////////
	// read mux
	////////////////////
	always_comb begin
		prdata = '0;
		case (paddr)
			REG_NUM:    prdata[`VJOB_NUM_BITS-1:0] = num_vertices;
			REG_DEGREE: prdata = degree_base;
			REG_EDGES:  prdata = edges_base;
			REG_FIRST:  prdata[`VJOB_VERTEX_BITS-1:0] = first_id;
			REG_STATUS: prdata[1:0] = {done, busy};
			default:    prdata = '0;
		endcase
	end

	////////////////////
	// write side
	////////////////////
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			num_vertices <= '0;
			degree_base  <= '0;
			edges_base   <= '0;
			first_id     <= '0;
			start        <= 1'b0;
		end else begin
			// one cycle pulse, dropped while a job runs
			start <= access && pwrite && (paddr == REG_CONTROL) && pwdata[0] && !busy;
			if (access && pwrite) begin
				case (paddr)
					REG_NUM:    num_vertices <= pwdata[`VJOB_NUM_BITS-1:0];
					REG_DEGREE: degree_base <= pwdata;
					REG_EDGES:  edges_base <= pwdata;
					REG_FIRST:  first_id <= pwdata[`VJOB_VERTEX_BITS-1:0];
					default:    ;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/vjob_pkg.sv ====
////////////////////
// vertex job controller types
// array tag and the two views of a data line
////////////////////

`default_nettype none

`include "vjob_params.svh"

package vjob_pkg;

	// which array a command or a response line belongs to
	typedef enum logic {
		TAG_DEGREE = 1'b0,
		TAG_EDGES  = 1'b1
	} array_tag_e;

	// one line, as loaded from memory or split into vertex words
	// word 0 sits in the low bits
	typedef union packed {
		logic [`VJOB_LINE_BITS-1:0]                            raw;
		logic [`VJOB_LINE_VERTICES-1:0][`VJOB_VERTEX_BITS-1:0] word;
	} vjob_line_u;

endpackage

`default_nettype wire

// ==== include/vjob_params.svh ====
////////////////////
// vertex job controller parameters
// bus widths, line geometry and queue depth
////////////////////

`ifndef VJOB_PARAMS_SVH
`define VJOB_PARAMS_SVH

// byte address and vertex word widths
`define VJOB_ADDR_BITS 32
`define VJOB_VERTEX_BITS 32

// one cache line holds eight vertex words
`define VJOB_LINE_VERTICES 8
`define VJOB_LINE_BITS 256
`define VJOB_LINE_BYTES 32
`define VJOB_COUNT_BITS 4

// job size and queue
`define VJOB_NUM_BITS 24
`define VJOB_FIFO_DEPTH 16
`define VJOB_APB_ADDR_BITS 8

`endif
